// ==== hdl/op_pkg.sv ====
package op_pkg;

  localparam int OP_W = 4;

  // memory operations, loads then stores, fetch last
  typedef enum logic [OP_W-1:0] {
    OP_LB     = 4'd0,
    OP_LBU    = 4'd1,
    OP_LH     = 4'd2,
    OP_LHU    = 4'd3,
    OP_LW     = 4'd4,
    OP_LWU    = 4'd5,
    OP_LD     = 4'd6,
    OP_SB     = 4'd7,
    OP_SH     = 4'd8,
    OP_SW     = 4'd9,
    OP_SD     = 4'd10,
    OP_IFETCH = 4'd11
  } mem_op_e;

  // access size in bytes
  function automatic logic [3:0] size_bytes(mem_op_e op);
    case (op)
      OP_LB, OP_LBU, OP_SB: return 4'd1;
      OP_LH, OP_LHU, OP_SH: return 4'd2;
      OP_LW, OP_LWU, OP_SW, OP_IFETCH: return 4'd4;
      default: return 4'd8;
    endcase
  endfunction

  function automatic logic is_store(mem_op_e op);
    return (op == OP_SB) || (op == OP_SH) || (op == OP_SW) || (op == OP_SD);
  endfunction

endpackage

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

  // byte address and word geometry
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 64;
  localparam int INST_W     = 32;
  localparam int MEM_WORDS  = 256;
  localparam int WORD_IDX_W = 8;
  localparam int OFFSET_W   = 3;

  // requester identity
  typedef enum logic {
    PORT_FETCH = 1'b0,
    PORT_DATA  = 1'b1
  } port_e;

  // sent with a request, returned with its response
  typedef struct packed {
    port_e                 port;
    op_pkg::mem_op_e       op;
    logic [OFFSET_W-1:0]   offset;
  } req_tag_t;

endpackage

// ==== hdl/mem_req_if.sv ====
`timescale 1ns/10ps

interface mem_req_if;

  logic                      valid;
  logic [bus_pkg::ADDR_W-1:0] addr;
  logic [bus_pkg::DATA_W-1:0] wdata;
  bus_pkg::req_tag_t          tag;

  // arbiter side
  modport arb_mp (
    output valid,
    output addr,
    output wdata,
    output tag
  );

  // memory side, every valid request is taken
  modport mem_mp (
    input valid,
    input addr,
    input wdata,
    input tag
  );

endinterface

// ==== hdl/request_arbiter.sv ====
`timescale 1ns/10ps

module request_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       fetch_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0] fetch_addr_i,
  output logic                       fetch_ready_o,
  input  logic                       data_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0] data_addr_i,
  input  op_pkg::mem_op_e            data_op_i,
  input  logic [bus_pkg::DATA_W-1:0] data_wdata_i,
  output logic                       data_ready_o,
  mem_req_if.arb_mp                  req
);

  // last grant, plus a hold state for the edge after reset
  typedef enum logic [1:0] {
    ARB_RESET      = 2'd0,
    ARB_LAST_FETCH = 2'd1,
    ARB_LAST_DATA  = 2'd2
  } arb_state_e;

  arb_state_e state_q;
  arb_state_e state_d;
  logic       grant_fetch;
  logic       grant_data;
  logic [bus_pkg::ADDR_W-1:0] sel_addr;

  always_comb begin
    grant_fetch = 1'b0;
    grant_data  = 1'b0;
    if (state_q != ARB_RESET) begin
      if (fetch_valid_i && data_valid_i) begin
        // tie goes to whoever waited last time
        grant_fetch = (state_q == ARB_LAST_DATA);
        grant_data  = (state_q == ARB_LAST_FETCH);
      end else begin
        grant_fetch = fetch_valid_i;
        grant_data  = data_valid_i;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    if (grant_fetch) begin
      state_d = ARB_LAST_FETCH;
    end else if (grant_data) begin
      state_d = ARB_LAST_DATA;
    end else if (state_q == ARB_RESET) begin
      state_d = ARB_LAST_DATA;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ARB_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  assign fetch_ready_o = grant_fetch;
  assign data_ready_o  = grant_data;

  assign sel_addr = grant_fetch ? fetch_addr_i : data_addr_i;

  // request toward the memory
  assign req.valid      = grant_fetch || grant_data;
  assign req.addr       = sel_addr;
  assign req.wdata      = grant_data ? data_wdata_i : '0;
  assign req.tag.port   = grant_fetch ? bus_pkg::PORT_FETCH : bus_pkg::PORT_DATA;
  assign req.tag.op     = grant_fetch ? op_pkg::OP_IFETCH : data_op_i;
  assign req.tag.offset = sel_addr[bus_pkg::OFFSET_W-1:0];

endmodule

// ==== hdl/data_memory.sv ====
`timescale 1ns/10ps

module data_memory (
  input  logic                       clk,
  input  logic                       rst,
  mem_req_if.mem_mp                  req,
  output logic                       rsp_valid_o,
  output logic [bus_pkg::DATA_W-1:0] rsp_word_o,
  output bus_pkg::req_tag_t          rsp_tag_o
);

  logic [bus_pkg::DATA_W-1:0]     mem_q [bus_pkg::MEM_WORDS];
  logic [bus_pkg::WORD_IDX_W-1:0] word_idx;
  logic [bus_pkg::DATA_W/8-1:0]   byte_en;
  logic [bus_pkg::DATA_W-1:0]     wdata_aligned;
  logic [15:0]                    be_wide;
  logic [3:0]                     size;

  // word index sits right above the byte offset
  assign word_idx = req.addr[bus_pkg::OFFSET_W +: bus_pkg::WORD_IDX_W];

  always_comb begin
    size = op_pkg::size_bytes(req.tag.op);
    // size ones, moved up to the offset
    be_wide = ((16'd1 << size) - 16'd1) << req.tag.offset;
    byte_en = '0;
    if (req.valid && op_pkg::is_store(req.tag.op)) begin
      byte_en = be_wide[bus_pkg::DATA_W/8-1:0];
    end
    // store data arrives in the low bytes
    wdata_aligned = req.wdata << {req.tag.offset, 3'b000};
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < bus_pkg::DATA_W/8; i++) begin
      if (byte_en[i]) begin
        mem_q[word_idx][i*8 +: 8] <= wdata_aligned[i*8 +: 8];
      end
    end
  end

  // read word is the content before this request's write
  always_ff @(posedge clk) begin
    if (req.valid) begin
      rsp_word_o <= mem_q[word_idx];
      rsp_tag_o  <= req.tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req.valid;
    end
  end

endmodule

// ==== hdl/load_formatter.sv ====
`timescale 1ns/10ps

module load_formatter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rsp_valid_i,
  input  logic [bus_pkg::DATA_W-1:0] rsp_word_i,
  input  bus_pkg::req_tag_t          rsp_tag_i,
  output logic                       fetch_rsp_valid_o,
  output logic [bus_pkg::INST_W-1:0] fetch_inst_o,
  output logic                       data_rsp_valid_o,
  output logic [bus_pkg::DATA_W-1:0] data_rdata_o
);

  logic [bus_pkg::DATA_W-1:0] shifted;
  logic [bus_pkg::DATA_W-1:0] size_mask;
  logic [bus_pkg::DATA_W-1:0] load_data;
  logic [3:0]                 size;
  logic                       top_bit;
  logic                       sign_load;
  logic                       to_fetch;
  logic                       to_data;

  always_comb begin
    // addressed bytes down to bit 0
    shifted = rsp_word_i >> {rsp_tag_i.offset, 3'b000};
    size    = op_pkg::size_bytes(rsp_tag_i.op);
    case (size)
      4'd1: begin
        size_mask = 64'h0000_0000_0000_00ff;
        top_bit   = shifted[7];
      end
      4'd2: begin
        size_mask = 64'h0000_0000_0000_ffff;
        top_bit   = shifted[15];
      end
      4'd4: begin
        size_mask = 64'h0000_0000_ffff_ffff;
        top_bit   = shifted[31];
      end
      default: begin
        size_mask = '1;
        top_bit   = shifted[63];
      end
    endcase
    sign_load = (rsp_tag_i.op == op_pkg::OP_LB) ||
                (rsp_tag_i.op == op_pkg::OP_LH) ||
                (rsp_tag_i.op == op_pkg::OP_LW);
    if (op_pkg::is_store(rsp_tag_i.op)) begin
      // write acknowledge carries no data
      load_data = '0;
    end else if (sign_load && top_bit) begin
      load_data = (shifted & size_mask) | ~size_mask;
    end else begin
      load_data = shifted & size_mask;
    end
  end

  assign to_fetch = rsp_valid_i && (rsp_tag_i.port == bus_pkg::PORT_FETCH);
  assign to_data  = rsp_valid_i && (rsp_tag_i.port == bus_pkg::PORT_DATA);

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_rsp_valid_o <= 1'b0;
      data_rsp_valid_o  <= 1'b0;
    end else begin
      fetch_rsp_valid_o <= to_fetch;
      data_rsp_valid_o  <= to_data;
    end
  end

  // fetch is a 4-byte zero-extended read, so the low half is the instruction
  always_ff @(posedge clk) begin
    if (to_fetch) begin
      fetch_inst_o <= load_data[bus_pkg::INST_W-1:0];
    end
    if (to_data) begin
      data_rdata_o <= load_data;
    end
  end

endmodule

// ==== hdl/mem_subsystem.sv ====
`timescale 1ns/10ps

module mem_subsystem (
  input  logic                       clk,
  input  logic                       rst,
  // instruction fetch port
  input  logic                       fetch_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0] fetch_addr_i,
  output logic                       fetch_ready_o,
  output logic                       fetch_rsp_valid_o,
  output logic [bus_pkg::INST_W-1:0] fetch_inst_o,
  // load/store port
  input  logic                       data_valid_i,
  input  logic [bus_pkg::ADDR_W-1:0] data_addr_i,
  input  op_pkg::mem_op_e            data_op_i,
  input  logic [bus_pkg::DATA_W-1:0] data_wdata_i,
  output logic                       data_ready_o,
  output logic                       data_rsp_valid_o,
  output logic [bus_pkg::DATA_W-1:0] data_rdata_o
);

  // memory to formatter
  logic                       rsp_valid;
  logic [bus_pkg::DATA_W-1:0] rsp_word;
  bus_pkg::req_tag_t          rsp_tag;

  mem_req_if req_bus ();

  request_arbiter u_arbiter (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .data_valid_i  (data_valid_i),
    .data_addr_i   (data_addr_i),
    .data_op_i     (data_op_i),
    .data_wdata_i  (data_wdata_i),
    .data_ready_o  (data_ready_o),
    .req           (req_bus.arb_mp)
  );

  data_memory u_memory (
    .clk         (clk),
    .rst         (rst),
    .req         (req_bus.mem_mp),
    .rsp_valid_o (rsp_valid),
    .rsp_word_o  (rsp_word),
    .rsp_tag_o   (rsp_tag)
  );

  load_formatter u_formatter (
    .clk               (clk),
    .rst               (rst),
    .rsp_valid_i       (rsp_valid),
    .rsp_word_i        (rsp_word),
    .rsp_tag_i         (rsp_tag),
    .fetch_rsp_valid_o (fetch_rsp_valid_o),
    .fetch_inst_o      (fetch_inst_o),
    .data_rsp_valid_o  (data_rsp_valid_o),
    .data_rdata_o      (data_rdata_o)
  );

endmodule

// ==== bench/tb_mem_subsystem.sv ====
`timescale 1ns/10ps

module tb_mem_subsystem;

  localparam int WAIT_LIMIT    = 40;
  localparam int MIXED_FETCHES = 160;
  localparam int MIXED_DATA    = 240;

  logic            clk = 1'b0;
  logic            rst;
  logic            fetch_valid;
  logic [31:0]     fetch_addr;
  logic            fetch_ready;
  logic            fetch_rsp_valid;
  logic [31:0]     fetch_inst;
  logic            data_valid;
  logic [31:0]     data_addr;
  op_pkg::mem_op_e data_op;
  logic [63:0]     data_wdata;
  logic            data_ready;
  logic            data_rsp_valid;
  logic [63:0]     data_rdata;

  // model of the memory contents and the expected responses per port
  logic [63:0] ref_mem [bus_pkg::MEM_WORDS];
  logic [63:0] fetch_exp_q [$];
  int          fetch_due_q [$];
  logic [63:0] data_exp_q [$];
  int          data_due_q [$];
  int          cyc = 0;

  op_pkg::mem_op_e load_ops [7] = '{op_pkg::OP_LB, op_pkg::OP_LBU, op_pkg::OP_LH,
                                    op_pkg::OP_LHU, op_pkg::OP_LW, op_pkg::OP_LWU,
                                    op_pkg::OP_LD};
  op_pkg::mem_op_e store_ops [4] = '{op_pkg::OP_SB, op_pkg::OP_SH, op_pkg::OP_SW,
                                     op_pkg::OP_SD};

  mem_subsystem dut0 (
    .clk               (clk),
    .rst               (rst),
    .fetch_valid_i     (fetch_valid),
    .fetch_addr_i      (fetch_addr),
    .fetch_ready_o     (fetch_ready),
    .fetch_rsp_valid_o (fetch_rsp_valid),
    .fetch_inst_o      (fetch_inst),
    .data_valid_i      (data_valid),
    .data_addr_i       (data_addr),
    .data_op_i         (data_op),
    .data_wdata_i      (data_wdata),
    .data_ready_o      (data_ready),
    .data_rsp_valid_o  (data_rsp_valid),
    .data_rdata_o      (data_rdata)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      fail_with($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic int access_bytes(op_pkg::mem_op_e op);
    case (op)
      op_pkg::OP_LB, op_pkg::OP_LBU, op_pkg::OP_SB: return 1;
      op_pkg::OP_LH, op_pkg::OP_LHU, op_pkg::OP_SH: return 2;
      op_pkg::OP_LD, op_pkg::OP_SD: return 8;
      default: return 4;
    endcase
  endfunction

  function automatic logic store_op(op_pkg::mem_op_e op);
    return (op == op_pkg::OP_SB) || (op == op_pkg::OP_SH) ||
           (op == op_pkg::OP_SW) || (op == op_pkg::OP_SD);
  endfunction

  // expected load, fetch or store acknowledge data
  function automatic logic [63:0] expected_result(op_pkg::mem_op_e op, logic [63:0] word,
                                                  logic [2:0] offset);
    logic [63:0] sh;
    sh = word >> (32'(offset) * 8);
    case (op)
      op_pkg::OP_LB:  return {{56{sh[7]}}, sh[7:0]};
      op_pkg::OP_LBU: return {56'd0, sh[7:0]};
      op_pkg::OP_LH:  return {{48{sh[15]}}, sh[15:0]};
      op_pkg::OP_LHU: return {48'd0, sh[15:0]};
      op_pkg::OP_LW:  return {{32{sh[31]}}, sh[31:0]};
      op_pkg::OP_LWU, op_pkg::OP_IFETCH: return {32'd0, sh[31:0]};
      op_pkg::OP_LD:  return sh;
      default: return 64'd0;
    endcase
  endfunction

  task automatic apply_store(input logic [31:0] addr, input op_pkg::mem_op_e op,
                             input logic [63:0] wdata);
    int idx;
    int off;
    idx = int'(addr[10:3]);
    off = int'(addr[2:0]);
    for (int b = 0; b < access_bytes(op); b++) begin
      ref_mem[idx][(off + b) * 8 +: 8] = wdata[b * 8 +: 8];
    end
  endtask

  function automatic logic [63:0] random64();
    return {$urandom, $urandom};
  endfunction

  // random word with an offset aligned to n bytes
  function automatic logic [31:0] random_addr(int n);
    logic [7:0] w;
    logic [2:0] off;
    w   = 8'($urandom);
    off = 3'(($urandom % (8 / n)) * n);
    return {21'd0, w, off};
  endfunction

  function automatic op_pkg::mem_op_e random_data_op();
    if ($urandom % 2 == 0) begin
      return load_ops[3'($urandom % 7)];
    end else begin
      return store_ops[2'($urandom % 4)];
    end
  endfunction

  task automatic compare_fetch();
    if (fetch_rsp_valid === 1'b1) begin
      if (fetch_exp_q.size() == 0) begin
        fail_with("fetch response arrived with no fetch outstanding");
      end else if (fetch_due_q[0] != cyc) begin
        fail_with($sformatf("fetch response at cycle %0d, expected at cycle %0d",
                            cyc, fetch_due_q[0]));
      end else begin
        check_value("fetch_inst_o", {32'd0, fetch_inst}, fetch_exp_q[0]);
        fetch_exp_q.delete(0);
        fetch_due_q.delete(0);
      end
    end else if (fetch_due_q.size() != 0 && fetch_due_q[0] <= cyc) begin
      fail_with($sformatf("fetch response missing at cycle %0d", cyc));
    end
  endtask

  task automatic compare_data();
    if (data_rsp_valid === 1'b1) begin
      if (data_exp_q.size() == 0) begin
        fail_with("data response arrived with no request outstanding");
      end else if (data_due_q[0] != cyc) begin
        fail_with($sformatf("data response at cycle %0d, expected at cycle %0d",
                            cyc, data_due_q[0]));
      end else begin
        check_value("data_rdata_o", data_rdata, data_exp_q[0]);
        data_exp_q.delete(0);
        data_due_q.delete(0);
      end
    end else if (data_due_q.size() != 0 && data_due_q[0] <= cyc) begin
      fail_with($sformatf("data response missing at cycle %0d", cyc));
    end
  endtask

  // model update at each accepted request
  task automatic record_requests();
    int idx;
    if (fetch_ready === 1'b1 && data_ready === 1'b1) begin
      fail_with("both ports granted in the same cycle");
    end
    if (fetch_valid === 1'b1 && fetch_ready === 1'b1) begin
      idx = int'(fetch_addr[10:3]);
      fetch_exp_q.push_back(expected_result(op_pkg::OP_IFETCH, ref_mem[idx], fetch_addr[2:0]));
      fetch_due_q.push_back(cyc + 2);
    end
    if (data_valid === 1'b1 && data_ready === 1'b1) begin
      idx = int'(data_addr[10:3]);
      data_exp_q.push_back(expected_result(data_op, ref_mem[idx], data_addr[2:0]));
      data_due_q.push_back(cyc + 2);
      if (store_op(data_op)) begin
        apply_store(data_addr, data_op, data_wdata);
      end
    end
  endtask

  // scoreboard
  always @(posedge clk) begin
    cyc = cyc + 1;
    if (!rst) begin
      compare_fetch();
      compare_data();
      record_requests();
    end
  end

  // starts at a falling edge and returns at the falling edge after acceptance
  task automatic fetch_request(input logic [31:0] addr);
    int waited;
    waited = 0;
    fetch_valid = 1'b1;
    fetch_addr  = addr;
    @(posedge clk);
    while (fetch_ready !== 1'b1) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        fail_with("fetch request was never accepted");
      end else begin
        @(posedge clk);
      end
    end
    @(negedge clk);
    fetch_valid = 1'b0;
  endtask

  task automatic data_request(input logic [31:0] addr, input op_pkg::mem_op_e op,
                              input logic [63:0] wdata);
    int waited;
    waited = 0;
    data_valid = 1'b1;
    data_addr  = addr;
    data_op    = op;
    data_wdata = wdata;
    @(posedge clk);
    while (data_ready !== 1'b1) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        fail_with("data request was never accepted");
      end else begin
        @(posedge clk);
      end
    end
    @(negedge clk);
    data_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_reset_outputs();
    check_value("fetch_ready_o", 64'(fetch_ready), 64'd0);
    check_value("data_ready_o", 64'(data_ready), 64'd0);
    check_value("fetch_rsp_valid_o", 64'(fetch_rsp_valid), 64'd0);
    check_value("data_rsp_valid_o", 64'(data_rsp_valid), 64'd0);
  endtask

  // both ports held valid with fetch granted first
  task automatic check_alternation();
    for (int k = 0; k < 12; k++) begin
      @(posedge clk);
      check_value("fetch_ready_o", 64'(fetch_ready), 64'(k % 2 == 0));
      check_value("data_ready_o", 64'(data_ready), 64'(k % 2 == 1));
    end
  endtask

  initial begin
    int unsigned seed_val;
    logic [63:0] wd;
    logic [31:0] base;
    logic [31:0] a;
    int          n;
    int          m;
    int          drain;
    seed_val    = $urandom(92);
    rst         = 1'b1;
    // valid during reset must not be granted
    fetch_valid = 1'b1;
    fetch_addr  = 32'd0;
    data_valid  = 1'b1;
    data_addr   = 32'd0;
    data_op     = op_pkg::OP_LD;
    data_wdata  = 64'd0;
    repeat (4) begin
      @(negedge clk);
      check_reset_outputs();
    end
    rst = 1'b0;
    @(posedge clk);
    check_reset_outputs();
    @(negedge clk);
    fetch_valid = 1'b0;
    data_valid  = 1'b0;

    // fill every word with stores that are acknowledged with zero data
    for (int w = 0; w < bus_pkg::MEM_WORDS; w++) begin
      data_request({21'd0, 8'(w), 3'd0}, op_pkg::OP_SD, random64());
    end

    // each store size followed by every load kind that fits inside it
    foreach (store_ops[s]) begin
      for (int r = 0; r < 2; r++) begin
        n  = access_bytes(store_ops[s]);
        wd = random64();
        wd = (r == 0) ? (wd | 64'h8080_8080_8080_8080) : (wd & 64'h7f7f_7f7f_7f7f_7f7f);
        base = random_addr(n);
        data_request(base, store_ops[s], wd);
        foreach (load_ops[k]) begin
          m = access_bytes(load_ops[k]);
          if (m <= n) begin
            a = base + 32'(($urandom % (n / m)) * m);
            data_request(a, load_ops[k], random64());
          end
        end
      end
    end

    // last grant was data here
    fork
      for (int k = 0; k < 6; k++) fetch_request(random_addr(4));
      for (int k = 0; k < 6; k++) data_request(random_addr(8), op_pkg::OP_LD, 64'd0);
      check_alternation();
    join

    // fetch of a word stored one edge earlier
    for (int k = 0; k < 8; k++) begin
      a = random_addr(8);
      data_request(a, op_pkg::OP_SD, random64());
      fetch_request(a);
      fetch_request(a | 32'd4);
    end
    for (int k = 0; k < 16; k++) begin
      fetch_request(random_addr(4));
    end

    // mixed traffic with random gaps on both ports
    fork
      begin : mixed_fetch
        for (int k = 0; k < MIXED_FETCHES; k++) begin
          idle_cycles(int'($urandom % 4));
          fetch_request(random_addr(4));
        end
      end
      begin : mixed_data
        op_pkg::mem_op_e op;
        for (int k = 0; k < MIXED_DATA; k++) begin
          idle_cycles(int'($urandom % 4));
          op = random_data_op();
          data_request(random_addr(access_bytes(op)), op, random64());
        end
      end
    join

    drain = 0;
    while ((fetch_exp_q.size() != 0 || data_exp_q.size() != 0) && drain < WAIT_LIMIT) begin
      @(negedge clk);
      drain++;
    end
    if (fetch_exp_q.size() != 0 || data_exp_q.size() != 0) begin
      fail_with("responses still outstanding at the end of the run");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
hdl/op_pkg.sv
hdl/bus_pkg.sv
hdl/mem_req_if.sv
hdl/request_arbiter.sv
hdl/data_memory.sv
hdl/load_formatter.sv
hdl/mem_subsystem.sv
bench/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
rm -rf obj_dir
verilator --binary --timescale 1ns/10ps --top-module tb_mem_subsystem \
  -f filelist.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_mem_subsystem > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
